// ==== osd_core_top.f ====
+incdir+tb
source/osd_core_pkg.sv
source/host_bus_fabric.sv
source/ctrl_regs.sv
source/osd_ram.sv
source/osd_raster.sv
source/osd_core_top.sv
tb/tb_osd_core_top.sv

// ==== Makefile ====
# Verilator build for the osd monitor core

VERILATOR  ?= verilator
TOP        := tb_osd_core_top
FILELIST   := osd_core_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the testbench ends with $fatal on any failure, so the run's exit status is the result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_osd_model.svh ====
/*
  reference model for the osd testbench
  ram bytes, control registers, raster counters and expected pixels
*/

`ifndef TB_OSD_MODEL_SVH
`define TB_OSD_MODEL_SVH

  localparam logic [23:0] FG_RGB = 24'hff_ff_ff;
  localparam logic [23:0] BG_RGB = 24'h30_40_50;

  logic [7:0]  ref_ram [int];
  logic        ref_osd_en;
  logic        ref_core_run;
  logic [63:0] ref_kbd;
  int          ref_x;
  int          ref_y;

  function automatic void store_bytes(input int word, input logic [31:0] dat,
                                      input logic [3:0] sel);
    for (int b = 0; b < 4; b++) begin
      if (((sel >> b) & 4'd1) != 4'd0) begin
        ref_ram[4 * word + b] = 8'(dat >> (8 * b));
      end
    end
  endfunction

  function automatic logic [31:0] load_word(input int word);
    return {ref_ram[4 * word + 3], ref_ram[4 * word + 2],
            ref_ram[4 * word + 1], ref_ram[4 * word]};
  endfunction

  // registers change on full word writes only
  function automatic void apply_reg_write(input logic [1:0] idx, input logic [31:0] dat,
                                          input logic [3:0] sel);
    if (sel == 4'hf) begin
      case (idx)
        2'd0:    ref_osd_en = dat[0];
        2'd1:    ref_kbd[31:0] = dat;
        2'd2:    ref_kbd[63:32] = dat;
        default: ref_core_run = dat[0];
      endcase
    end
  endfunction

  function automatic logic [31:0] reg_value(input logic [1:0] idx);
    case (idx)
      2'd0:    return {31'd0, ref_osd_en};
      2'd1:    return ref_kbd[31:0];
      2'd2:    return ref_kbd[63:32];
      default: return {31'd0, ref_core_run};
    endcase
  endfunction

  // {hs, vs, de, rgb} for one input cycle, then the counters advance
  function automatic logic [26:0] expect_video(input logic hs, input logic vs,
                                               input logic de, input logic [23:0] rgb);
    logic [23:0] pix;
    logic [7:0]  bits;
    if (!de) begin
      pix = '0;
    end else if (ref_osd_en && ref_y < 64 && ref_x < 256) begin
      // leftmost pixel in the msb
      bits = ref_ram[ref_y * 32 + ref_x / 8] << (ref_x % 8);
      pix  = bits[7] ? FG_RGB : BG_RGB;
    end else begin
      pix = rgb;
    end
    if (hs) begin
      if (ref_x != 0) begin
        ref_y++;
      end
      ref_x = 0;
    end else if (de) begin
      ref_x++;
    end
    if (vs) begin
      ref_y = 0;
    end
    return {hs, vs, de, pix};
  endfunction

`endif

// ==== tb/tb_osd_core_top.sv ====
/*
  testbench for the osd monitor top level
  clock and reset, lfsr stimulus, wishbone tasks, video checker
  and the reset, ram, register, key, overlay and contention tests
*/

`default_nettype none

module tb_osd_core_top;

  localparam int RAM_AW = 10;
  localparam int RAM_WORDS = 2**RAM_AW;
  localparam int BITMAP_WORDS = 512;
  localparam int ACK_TIMEOUT = 20;
  localparam int KEY_SETTLE = 5;

  logic        clk;
  logic        rst;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [31:0] i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [3:0]  i_wb_sel;
  logic        o_wb_ack;
  logic [31:0] o_wb_dat;
  logic [15:0] i_cont_key;
  logic        i_vid_hs;
  logic        i_vid_vs;
  logic        i_vid_de;
  logic [23:0] i_core_rgb;
  logic        o_vid_hs;
  logic        o_vid_vs;
  logic        o_vid_de;
  logic [23:0] o_video_rgb;
  logic        o_core_run;
  logic [63:0] o_keyboard_mask;

  logic [31:0] lfsr;

  // expected video two cycles deep
  logic [26:0] exp_d1;
  logic [26:0] exp_d2;
  logic        valid_d1;
  logic        valid_d2;

  `include "tb_osd_model.svh"

  osd_core_top #(
    .RAM_AW(RAM_AW)
  ) DUT (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // random numbers

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // failures

  task automatic fail_now(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      fail_now($sformatf("[FAIL] %s: expected %0h, actual %0h", name, exp, got));
    end
  endtask

  ////////////////////////////////////////
  // wishbone master

  function automatic logic [31:0] ram_adr(input int word);
    return {4'h1, 26'(word), 2'b00};
  endfunction

  function automatic logic [31:0] ctrl_adr(input logic [1:0] idx);
    return {4'h3, 24'd0, idx, 2'b00};
  endfunction

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_wb_ack !== 1'b1 && n < ACK_TIMEOUT);
    assert (o_wb_ack === 1'b1) else begin
      fail_now($sformatf("timeout waiting for the wishbone ack of a %s", what));
    end
  endtask

  // drop the strobe, then ack must already be gone
  task automatic end_cycle();
    @(posedge clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    @(negedge clk);
    check_value("ack pulse width", 64'd0, 64'(o_wb_ack));
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    @(posedge clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= 1'b1;
    i_wb_adr <= adr;
    i_wb_dat <= dat;
    i_wb_sel <= sel;
    wait_ack("write");
    end_cycle();
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
    @(posedge clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= 1'b0;
    i_wb_adr <= adr;
    i_wb_sel <= 4'hf;
    wait_ack("read");
    dat = o_wb_dat;
    end_cycle();
  endtask

  task automatic write_ram(input int word, input logic [31:0] dat, input logic [3:0] sel);
    bus_write(ram_adr(word), dat, sel);
    store_bytes(word, dat, sel);
  endtask

  task automatic write_reg(input logic [1:0] idx, input logic [31:0] dat, input logic [3:0] sel);
    bus_write(ctrl_adr(idx), dat, sel);
    apply_reg_write(idx, dat, sel);
  endtask

  task automatic verify_regs(input string name);
    logic [31:0] rd;
    for (int i = 0; i < 4; i++) begin
      bus_read(ctrl_adr(2'(i)), rd);
      check_value(name, 64'(reg_value(2'(i))), 64'(rd));
    end
    check_value({name, " core_run"}, 64'(ref_core_run), 64'(o_core_run));
    check_value({name, " keyboard_mask"}, ref_kbd, o_keyboard_mask);
  endtask

  // random ram traffic, writes kept out of the bitmap
  task automatic bus_traffic(input int ops);
    int          w;
    logic [31:0] d;
    for (int k = 0; k < ops; k++) begin
      if (rand_bits(1) == 32'd1) begin
        w = BITMAP_WORDS + int'(rand_bits(RAM_AW - 1));
        write_ram(w, rand_bits(32), 4'(rand_bits(4)));
      end else begin
        w = int'(rand_bits(RAM_AW));
        bus_read(ram_adr(w), d);
        check_value("ram under contention", 64'(load_word(w)), 64'(d));
      end
    end
  endtask

  ////////////////////////////////////////
  // video source and checker

  task automatic drive_video(input logic hs, input logic vs, input logic de, input logic [23:0] rgb);
    @(posedge clk);
    i_vid_hs   <= hs;
    i_vid_vs   <= vs;
    i_vid_de   <= de;
    i_core_rgb <= rgb;
  endtask

  task automatic run_frame(input int lines, input int pixels, input bit use_lfsr);
    logic [23:0] rgb;
    drive_video(1'b0, 1'b1, 1'b0, 24'd0);
    drive_video(1'b0, 1'b0, 1'b0, 24'd0);
    for (int ln = 0; ln < lines; ln++) begin
      for (int px = 0; px < pixels; px++) begin
        rgb = use_lfsr ? 24'(rand_bits(24)) : {8'(ln), 16'(px)};
        drive_video(1'b0, 1'b0, 1'b1, rgb);
      end
      drive_video(1'b0, 1'b0, 1'b0, 24'd0);
      drive_video(1'b1, 1'b0, 1'b0, 24'd0);
      drive_video(1'b1, 1'b0, 1'b0, 24'd0);
      drive_video(1'b0, 1'b0, 1'b0, 24'd0);
    end
    // let the pipeline drain
    repeat (3) drive_video(1'b0, 1'b0, 1'b0, 24'd0);
  endtask

  always @(negedge clk) begin
    if (rst) begin
      ref_x    = 0;
      ref_y    = 0;
      valid_d1 = 1'b0;
      valid_d2 = 1'b0;
    end else begin
      if (valid_d2) begin
        check_value("video output", 64'(exp_d2),
                    64'({o_vid_hs, o_vid_vs, o_vid_de, o_video_rgb}));
      end
      exp_d2   = exp_d1;
      valid_d2 = valid_d1;
      exp_d1   = expect_video(i_vid_hs, i_vid_vs, i_vid_de, i_core_rgb);
      valid_d1 = 1'b1;
    end
  end

  ////////////////////////////////////////
  // tests

  initial begin
    logic [3:0]  region;
    logic [31:0] adr;
    logic [31:0] rd;
    logic [15:0] key;
    logic [3:0]  sel;
    lfsr         = 32'd93;
    rst          = 1'b1;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_adr     = '0;
    i_wb_dat     = '0;
    i_wb_sel     = '0;
    i_cont_key   = '0;
    i_vid_hs     = 1'b0;
    i_vid_vs     = 1'b0;
    i_vid_de     = 1'b0;
    i_core_rgb   = '0;
    ref_osd_en   = 1'b0;
    ref_core_run = 1'b0;
    ref_kbd      = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // reset state and unmapped regions
    check_value("reset core_run", 64'd0, 64'(o_core_run));
    check_value("reset keyboard_mask", 64'd0, o_keyboard_mask);
    for (int k = 0; k < 8; k++) begin
      region = 4'(rand_bits(4));
      if (region >= 4'h1 && region <= 4'h3) begin
        region = 4'h0;
      end
      adr = {region, 28'(rand_bits(28))};
      bus_write(adr, rand_bits(32), 4'hf);
      bus_read(adr, rd);
      check_value("unmapped read", 64'd0, 64'(rd));
    end
    verify_regs("reset registers");

    // ram with partial lanes
    for (int i = 0; i < RAM_WORDS; i++) begin
      write_ram(i, 32'(i) * 32'h9e37_79b1, 4'hf);
    end
    for (int k = 0; k < 64; k++) begin
      write_ram(int'(rand_bits(RAM_AW)), rand_bits(32), 4'(rand_bits(4)));
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      bus_read(ram_adr(i), rd);
      check_value("ram readback", 64'(load_word(i)), 64'(rd));
    end

    // control registers
    write_reg(2'd1, rand_bits(32), 4'hf);
    write_reg(2'd2, rand_bits(32), 4'hf);
    write_reg(2'd3, 32'd1, 4'hf);
    verify_regs("full writes");
    for (int k = 0; k < 8; k++) begin
      // any lane pattern short of a full word
      sel = 4'(rand_bits(4));
      if (sel == 4'hf) begin
        sel[2'(rand_bits(2))] = 1'b0;
      end
      write_reg(2'(rand_bits(2)), rand_bits(32), sel);
    end
    verify_regs("partial writes");
    write_reg(2'd3, 32'd0, 4'hf);
    verify_regs("core_run clear");

    // controller keys
    for (int k = 0; k < 8; k++) begin
      key = 16'(rand_bits(16));
      @(posedge clk);
      i_cont_key <= key;
      repeat (KEY_SETTLE) @(posedge clk);
      bus_read({4'h2, 28'(rand_bits(28))}, rd);
      check_value("key readout", 64'(key), 64'(rd));
    end

    // overlay frame over random core colours
    for (int i = 0; i < BITMAP_WORDS; i++) begin
      write_ram(i, rand_bits(32), 4'hf);
    end
    write_reg(2'd0, 32'd1, 4'hf);
    run_frame(68, 272, 1'b1);

    // host traffic during active overlay lines
    fork
      run_frame(8, 264, 1'b0);
      bus_traffic(300);
    join

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/osd_core_top.sv ====
/*
  osd monitor top level
  wishbone fabric, control registers, shared ram and osd raster
*/

`default_nettype none

module osd_core_top
  import osd_core_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic                  clk,
  input  logic                  rst,

  // wishbone classic slave
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  logic [31:0]           i_wb_adr,
  input  logic [WORD_W-1:0]     i_wb_dat,
  input  logic [LANES-1:0]      i_wb_sel,
  output logic                  o_wb_ack,
  output logic [WORD_W-1:0]     o_wb_dat,

  // player one controller
  input  logic [KEY_W-1:0]      i_cont_key,

  // video from the emulated core
  input  logic                  i_vid_hs,
  input  logic                  i_vid_vs,
  input  logic                  i_vid_de,
  input  logic [RGB_W-1:0]      i_core_rgb,

  output logic                  o_vid_hs,
  output logic                  o_vid_vs,
  output logic                  o_vid_de,
  output logic [RGB_W-1:0]      o_video_rgb,

  output logic                  o_core_run,
  output logic [KBD_MASK_W-1:0] o_keyboard_mask
);

  // raster fetch port
  logic                fetch;
  logic [FETCH_AW-1:0] fetch_addr;

  // shared ram port
  logic [RAM_AW-1:0]   ram_addr;
  logic [WORD_W-1:0]   ram_wdata;
  logic [LANES-1:0]    ram_we;
  logic [WORD_W-1:0]   ram_rdata;

  // register port
  logic                reg_stb;
  logic                reg_we;
  logic [1:0]          reg_idx;
  logic [WORD_W-1:0]   reg_wdata;
  logic [LANES-1:0]    reg_wsel;
  logic [WORD_W-1:0]   reg_rdata;

  logic                osd_en;

  host_bus_fabric #(
    .RAM_AW(RAM_AW)
  ) u_fabric (
    .clk         (clk),
    .rst         (rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .i_wb_sel    (i_wb_sel),
    .o_wb_ack    (o_wb_ack),
    .o_wb_dat    (o_wb_dat),
    .i_cont_key  (i_cont_key),
    .i_fetch     (fetch),
    .i_fetch_addr(fetch_addr),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata),
    .o_ram_we    (ram_we),
    .i_ram_rdata (ram_rdata),
    .o_reg_stb   (reg_stb),
    .o_reg_we    (reg_we),
    .o_reg_idx   (reg_idx),
    .o_reg_wdata (reg_wdata),
    .o_reg_wsel  (reg_wsel),
    .i_reg_rdata (reg_rdata)
  );

  ctrl_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .i_reg_stb      (reg_stb),
    .i_reg_we       (reg_we),
    .i_reg_idx      (reg_idx),
    .i_reg_wdata    (reg_wdata),
    .i_reg_wsel     (reg_wsel),
    .o_reg_rdata    (reg_rdata),
    .o_osd_en       (osd_en),
    .o_core_run     (o_core_run),
    .o_keyboard_mask(o_keyboard_mask)
  );

  osd_ram #(
    .RAM_AW(RAM_AW)
  ) u_ram (
    .clk    (clk),
    .i_addr (ram_addr),
    .i_wdata(ram_wdata),
    .i_we   (ram_we),
    .o_rdata(ram_rdata)
  );

  osd_raster u_raster (
    .clk         (clk),
    .rst         (rst),
    .i_osd_en    (osd_en),
    .i_vid_hs    (i_vid_hs),
    .i_vid_vs    (i_vid_vs),
    .i_vid_de    (i_vid_de),
    .i_core_rgb  (i_core_rgb),
    .o_fetch     (fetch),
    .o_fetch_addr(fetch_addr),
    .i_ram_rdata (ram_rdata),
    .o_vid_hs    (o_vid_hs),
    .o_vid_vs    (o_vid_vs),
    .o_vid_de    (o_vid_de),
    .o_video_rgb (o_video_rgb)
  );

endmodule

`default_nettype wire

// ==== source/osd_raster.sv ====
/*
  osd raster
  pixel counters, bitmap fetch, pixel shifter and video mux
  all video outputs trail the inputs by two clocks
*/

`default_nettype none

module osd_raster
  import osd_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                i_osd_en,

  input  logic                i_vid_hs,
  input  logic                i_vid_vs,
  input  logic                i_vid_de,
  input  logic [RGB_W-1:0]    i_core_rgb,

  output logic                o_fetch,
  output logic [FETCH_AW-1:0] o_fetch_addr,
  input  logic [WORD_W-1:0]   i_ram_rdata,

  output logic                o_vid_hs,
  output logic                o_vid_vs,
  output logic                o_vid_de,
  output logic [RGB_W-1:0]    o_video_rgb
);

  logic [POS_W-1:0] x;
  logic [POS_W-1:0] y;
  logic             osd_active;

  // stage 1
  logic             fetch_p1;
  logic [1:0]       lane_p1;
  logic             active_p1;
  logic             hs_p1;
  logic             vs_p1;
  logic             de_p1;
  logic [RGB_W-1:0] rgb_p1;
  logic [7:0]       fetch_byte;

  // stage 2
  logic             active_p2;
  logic [RGB_W-1:0] rgb_p2;
  logic [7:0]       pix_shift;
  logic [RGB_W-1:0] osd_rgb;

  ////////////////////////////////////////
  // pixel counters

  always_ff @(posedge clk) begin
    if (rst) begin
      x <= '0;
      y <= '0;
    end else begin
      if (i_vid_hs) begin
        x <= '0;
      end else if (i_vid_de) begin
        x <= x + 1'b1;
      end
      // a nonzero x means the line had active pixels
      if (i_vid_vs) begin
        y <= '0;
      end else if (i_vid_hs && x != '0) begin
        y <= y + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // window and fetch

  assign osd_active = i_osd_en & i_vid_de & (y < POS_W'(OSD_HEIGHT)) & (x < POS_W'(OSD_WIDTH));

  // one byte every eight pixels
  assign o_fetch      = osd_active & (x[2:0] == 3'd0);
  assign o_fetch_addr = FETCH_AW'(y * OSD_BYTES_PER_LINE) + FETCH_AW'(x >> 3);

  ////////////////////////////////////////
  // two-stage video pipeline

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_p1  <= 1'b0;
      active_p1 <= 1'b0;
      hs_p1     <= 1'b0;
      vs_p1     <= 1'b0;
      de_p1     <= 1'b0;
      active_p2 <= 1'b0;
      o_vid_hs  <= 1'b0;
      o_vid_vs  <= 1'b0;
      o_vid_de  <= 1'b0;
    end else begin
      fetch_p1  <= o_fetch;
      active_p1 <= osd_active;
      hs_p1     <= i_vid_hs;
      vs_p1     <= i_vid_vs;
      de_p1     <= i_vid_de;
      active_p2 <= active_p1;
      o_vid_hs  <= hs_p1;
      o_vid_vs  <= vs_p1;
      o_vid_de  <= de_p1;
    end
  end

  always_ff @(posedge clk) begin
    lane_p1 <= o_fetch_addr[1:0];
    rgb_p1  <= i_core_rgb;
    rgb_p2  <= rgb_p1;
    // msb is the leftmost pixel
    if (fetch_p1) begin
      pix_shift <= fetch_byte;
    end else begin
      pix_shift <= {pix_shift[6:0], 1'b0};
    end
  end

  // ram word arrives one cycle after the fetch
  always_comb begin
    case (lane_p1)
      2'd0:    fetch_byte = i_ram_rdata[7:0];
      2'd1:    fetch_byte = i_ram_rdata[15:8];
      2'd2:    fetch_byte = i_ram_rdata[23:16];
      default: fetch_byte = i_ram_rdata[31:24];
    endcase
  end

  ////////////////////////////////////////
  // colour

  assign osd_rgb = pix_shift[7] ? OSD_FG_RGB : OSD_BG_RGB;

  assign o_video_rgb = !o_vid_de ? '0 : (active_p2 ? osd_rgb : rgb_p2);

endmodule

`default_nettype wire

// ==== source/osd_ram.sv ====
/*
  shared pixel and data ram
  one byte array per lane, registered read
*/

`default_nettype none

module osd_ram
  import osd_core_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic [RAM_AW-1:0] i_addr,
  input  logic [WORD_W-1:0] i_wdata,
  input  logic [LANES-1:0]  i_we,
  output logic [WORD_W-1:0] o_rdata
);

  genvar gi;

  ////////////////////////////////////////
  // byte lanes

  generate
    for (gi = 0; gi < LANES; gi++) begin : g_lane
      logic [7:0] mem [2**RAM_AW];
      logic [7:0] rd_q;

      // read sees the old byte when written in the same cycle
      always_ff @(posedge clk) begin
        if (i_we[gi]) begin
          mem[i_addr] <= i_wdata[gi*8 +: 8];
        end
        rd_q <= mem[i_addr];
      end

      assign o_rdata[gi*8 +: 8] = rd_q;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== source/ctrl_regs.sv ====
/*
  control registers
  osd enable, core run bit and the 64-bit keyboard mask
*/

`default_nettype none

module ctrl_regs
  import osd_core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  i_reg_stb,
  input  logic                  i_reg_we,
  input  logic [1:0]            i_reg_idx,
  input  logic [WORD_W-1:0]     i_reg_wdata,
  input  logic [LANES-1:0]      i_reg_wsel,
  output logic [WORD_W-1:0]     o_reg_rdata,

  output logic                  o_osd_en,
  output logic                  o_core_run,
  output logic [KBD_MASK_W-1:0] o_keyboard_mask
);

  logic wr;

  // only full word writes land
  assign wr = i_reg_stb & i_reg_we & (&i_reg_wsel);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_osd_en        <= 1'b0;
      o_core_run      <= 1'b0;
      o_keyboard_mask <= '0;
    end else if (wr) begin
      case (i_reg_idx)
        REG_OSD_EN:   o_osd_en <= i_reg_wdata[0];
        REG_KBD_LO:   o_keyboard_mask[WORD_W-1:0] <= i_reg_wdata;
        REG_KBD_HI:   o_keyboard_mask[KBD_MASK_W-1:WORD_W] <= i_reg_wdata;
        REG_CORE_RUN: o_core_run <= i_reg_wdata[0];
      endcase
    end
  end

  ////////////////////////////////////////
  // readback

  always_comb begin
    case (i_reg_idx)
      REG_OSD_EN:   o_reg_rdata = WORD_W'(o_osd_en);
      REG_KBD_LO:   o_reg_rdata = o_keyboard_mask[WORD_W-1:0];
      REG_KBD_HI:   o_reg_rdata = o_keyboard_mask[KBD_MASK_W-1:WORD_W];
      REG_CORE_RUN: o_reg_rdata = WORD_W'(o_core_run);
      default:      o_reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/host_bus_fabric.sv ====
/*
  wishbone slave fabric
  region decode, ack generation, read data mux,
  ram arbitration against the raster and key synchroniser
*/

`default_nettype none

module host_bus_fabric
  import osd_core_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic                clk,
  input  logic                rst,

  input  logic                i_wb_cyc,
  input  logic                i_wb_stb,
  input  logic                i_wb_we,
  input  logic [31:0]         i_wb_adr,
  input  logic [WORD_W-1:0]   i_wb_dat,
  input  logic [LANES-1:0]    i_wb_sel,
  output logic                o_wb_ack,
  output logic [WORD_W-1:0]   o_wb_dat,

  input  logic [KEY_W-1:0]    i_cont_key,

  input  logic                i_fetch,
  input  logic [FETCH_AW-1:0] i_fetch_addr,

  output logic [RAM_AW-1:0]   o_ram_addr,
  output logic [WORD_W-1:0]   o_ram_wdata,
  output logic [LANES-1:0]    o_ram_we,
  input  logic [WORD_W-1:0]   i_ram_rdata,

  output logic                o_reg_stb,
  output logic                o_reg_we,
  output logic [1:0]          o_reg_idx,
  output logic [WORD_W-1:0]   o_reg_wdata,
  output logic [LANES-1:0]    o_reg_wsel,
  input  logic [WORD_W-1:0]   i_reg_rdata
);

  logic [3:0]        region;
  logic              req;
  logic              is_ram;
  logic              ram_go;
  logic              ack_q;
  logic [RAM_AW-1:0] fetch_word;
  logic [WORD_W-1:0] key_word;
  logic [KEY_W-1:0]  key_sync [SYNC_STAGES];

  ////////////////////////////////////////
  // decode

  assign region = i_wb_adr[31:28];
  assign is_ram = (region == REGION_RAM);

  // a request is live until its ack goes out
  assign req = i_wb_cyc & i_wb_stb & ~ack_q;

  // host gets the ram only when the raster leaves it free
  assign ram_go = req & is_ram & ~i_fetch;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= (req & ~is_ram) | ram_go;
    end
  end

  assign o_wb_ack = ack_q;

  ////////////////////////////////////////
  // ram port

  // byte address from the raster, word address to the ram
  assign fetch_word = RAM_AW'(i_fetch_addr[FETCH_AW-1:2]);

  assign o_ram_addr  = i_fetch ? fetch_word : i_wb_adr[RAM_AW+1:2];
  assign o_ram_wdata = i_wb_dat;
  assign o_ram_we    = (ram_go & i_wb_we) ? i_wb_sel : '0;

  ////////////////////////////////////////
  // register port

  assign o_reg_stb   = req & (region == REGION_CTRL);
  assign o_reg_we    = i_wb_we;
  assign o_reg_idx   = i_wb_adr[3:2];
  assign o_reg_wdata = i_wb_dat;
  assign o_reg_wsel  = i_wb_sel;

  ////////////////////////////////////////
  // controller keys

  always_ff @(posedge clk) begin
    key_sync[0] <= i_cont_key;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      key_sync[i] <= key_sync[i-1];
    end
  end

  assign key_word = WORD_W'(key_sync[SYNC_STAGES-1]);

  ////////////////////////////////////////
  // read data

  // address is still held in the ack cycle
  always_comb begin
    case (region)
      REGION_RAM:  o_wb_dat = i_ram_rdata;
      REGION_KEYS: o_wb_dat = key_word;
      REGION_CTRL: o_wb_dat = i_reg_rdata;
      default:     o_wb_dat = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/osd_core_pkg.sv ====
/*
  shared constants for the osd monitor core
  region codes, control register offsets, overlay geometry,
  colours and common widths
*/

`default_nettype none

package osd_core_pkg;

  ////////////////////////////////////////
  // bus words

  localparam int WORD_W = 32;
  localparam int LANES = WORD_W / 8;

  // address bits 31..28
  localparam logic [3:0] REGION_RAM = 4'h1;
  localparam logic [3:0] REGION_KEYS = 4'h2;
  localparam logic [3:0] REGION_CTRL = 4'h3;

  // word offsets in the control region
  localparam logic [1:0] REG_OSD_EN = 2'd0;
  localparam logic [1:0] REG_KBD_LO = 2'd1;
  localparam logic [1:0] REG_KBD_HI = 2'd2;
  localparam logic [1:0] REG_CORE_RUN = 2'd3;

  ////////////////////////////////////////
  // overlay

  localparam int OSD_WIDTH = 256;
  localparam int OSD_HEIGHT = 64;
  localparam int OSD_BYTES_PER_LINE = OSD_WIDTH / 8;

  // byte address into the 2 KB bitmap
  localparam int FETCH_AW = 11;

  localparam int POS_W = 9;
  localparam int RGB_W = 24;

  localparam logic [RGB_W-1:0] OSD_FG_RGB = 24'hff_ff_ff;
  localparam logic [RGB_W-1:0] OSD_BG_RGB = 24'h30_40_50;

  ////////////////////////////////////////
  // core side

  localparam int KBD_MASK_W = 64;
  localparam int KEY_W = 16;
  localparam int SYNC_STAGES = 3;

endpackage

`default_nettype wire
